// File: source/spu_decode_pkg.sv
package spu_decode_pkg;

	typedef logic [0:31] instr_t;	// bit 0 is the msb
	typedef logic [0:6] reg_addr_t;
	typedef logic [0:17] imm_t;	// already sign-extended

	typedef enum logic [2:0] {
		fmt_rr,
		fmt_rrr,
		fmt_ri7,
		fmt_ri8,
		fmt_ri10,
		fmt_ri16,
		fmt_ri18
	} format_e;

	typedef enum logic [1:0] {
		unit_fp,
		unit_fx2,
		unit_byte,
		unit_fx1
	} even_unit_e;

	typedef enum logic [1:0] {
		unit_perm,
		unit_ls,
		unit_br
	} odd_unit_e;

	// grouped by unit so the decoders can test ranges
	typedef enum logic [5:0] {
		even_none,	// zero encoding keeps an empty slot all zeros
		nop,
		mpya, fma, fms, cflts, cfltu, mpyi, mpyui,	// fp
		mpy, mpyu, mpyh, fa, fs, fm, fceq, fcgt,
		cntb, avgb, absdb, sumb,	// byte
		ila, ilh, ilhu, iohl,	// fx1
		ahi, ai, sfhi, sfi, andi, ori, xori, ceqi, cgti, clgti,
		ah, a_op, sfh, sf, and_op, or_op, xor_op, nand_op,
		ceqh, ceq, cgth, cgt, clgth, clgt,
		shlh, shl, roth, rot, rothm, rotm, rotmah, rotma,	// fx2
		shli, rothi, roti, rotmahi, rotmai
	} even_op_e;

	typedef enum logic [4:0] {
		odd_none,
		lnop,
		lqd, stqd, lqa, stqa, lqx, stqx,	// load/store
		br, bra, brsl, brnz, brz, bi,	// branch
		shlqbi, shlqby, rotqbi, rotqby, gbb, gbh, gb,	// permute
		shlqbii, shlqbyi, rotqbii, rotqbyi
	} odd_op_e;

	typedef enum logic [1:0] {
		pair_dual,
		pair_split,
		pair_last,
		pair_stop
	} pair_kind_e;

	typedef struct packed {
		instr_t instr;
		even_op_e op;
		format_e format;
		even_unit_e unit;
		reg_addr_t rt;
		reg_addr_t ra;
		reg_addr_t rb;
		reg_addr_t rc;
		imm_t imm;
		logic reg_write;
	} even_slot_t;

	typedef struct packed {
		instr_t instr;
		odd_op_e op;
		format_e format;
		odd_unit_e unit;
		reg_addr_t rt;
		reg_addr_t ra;
		reg_addr_t rb;
		imm_t imm;
		logic reg_write;
	} odd_slot_t;

	typedef struct packed {
		instr_t first;
		instr_t second;
	} fetch_pair_t;

	typedef struct packed {
		even_slot_t even_slot;
		odd_slot_t odd_slot;
		logic first_odd;	// odd instr came first in program order
	} issue_packet_t;

endpackage

// File: source/even_decoder.sv
`timescale 1ns/10ps

module even_decoder (
	input spu_decode_pkg::instr_t word,
	output spu_decode_pkg::even_slot_t slot
);

	spu_decode_pkg::even_op_e op;
	spu_decode_pkg::format_e fmt;
	spu_decode_pkg::even_unit_e unit;
	spu_decode_pkg::imm_t imm;

	// short opcodes have priority, so they are matched last and override
	always_comb begin
		case (word[0:10])	// rr and ri7
			11'b01111000100: op = spu_decode_pkg::mpy;
			11'b01111001100: op = spu_decode_pkg::mpyu;
			11'b01111000101: op = spu_decode_pkg::mpyh;
			11'b01011000100: op = spu_decode_pkg::fa;
			11'b01011000101: op = spu_decode_pkg::fs;
			11'b01011000110: op = spu_decode_pkg::fm;
			11'b01111000010: op = spu_decode_pkg::fceq;
			11'b01011000010: op = spu_decode_pkg::fcgt;
			11'b00001011111: op = spu_decode_pkg::shlh;
			11'b00001011011: op = spu_decode_pkg::shl;
			11'b00001011100: op = spu_decode_pkg::roth;
			11'b00001011000: op = spu_decode_pkg::rot;
			11'b00001011101: op = spu_decode_pkg::rothm;
			11'b00001011001: op = spu_decode_pkg::rotm;
			11'b00001011110: op = spu_decode_pkg::rotmah;
			11'b00001011010: op = spu_decode_pkg::rotma;
			11'b01010110100: op = spu_decode_pkg::cntb;
			11'b00011010011: op = spu_decode_pkg::avgb;
			11'b00001010011: op = spu_decode_pkg::absdb;
			11'b01001010011: op = spu_decode_pkg::sumb;
			11'b00011001000: op = spu_decode_pkg::ah;
			11'b00011000000: op = spu_decode_pkg::a_op;
			11'b00001001000: op = spu_decode_pkg::sfh;
			11'b00001000000: op = spu_decode_pkg::sf;
			11'b00011000001: op = spu_decode_pkg::and_op;
			11'b00001000001: op = spu_decode_pkg::or_op;
			11'b01001000001: op = spu_decode_pkg::xor_op;
			11'b00011001001: op = spu_decode_pkg::nand_op;
			11'b01111001000: op = spu_decode_pkg::ceqh;
			11'b01111000000: op = spu_decode_pkg::ceq;
			11'b01001001000: op = spu_decode_pkg::cgth;
			11'b01001000000: op = spu_decode_pkg::cgt;
			11'b01011001000: op = spu_decode_pkg::clgth;
			11'b01011000000: op = spu_decode_pkg::clgt;
			11'b01000000001: op = spu_decode_pkg::nop;
			11'b00001111011: op = spu_decode_pkg::shli;
			11'b00001111100: op = spu_decode_pkg::rothi;
			11'b00001111000: op = spu_decode_pkg::roti;
			11'b00001111110: op = spu_decode_pkg::rotmahi;
			11'b00001111010: op = spu_decode_pkg::rotmai;
			default: op = spu_decode_pkg::even_none;
		endcase
		case (word[0:7])	// ri10
			8'b01110100: op = spu_decode_pkg::mpyi;
			8'b01110101: op = spu_decode_pkg::mpyui;
			8'b00011101: op = spu_decode_pkg::ahi;
			8'b00011100: op = spu_decode_pkg::ai;
			8'b00001101: op = spu_decode_pkg::sfhi;
			8'b00001100: op = spu_decode_pkg::sfi;
			8'b00010100: op = spu_decode_pkg::andi;
			8'b00000100: op = spu_decode_pkg::ori;
			8'b01000100: op = spu_decode_pkg::xori;
			8'b01111100: op = spu_decode_pkg::ceqi;
			8'b01001100: op = spu_decode_pkg::cgti;
			8'b01011100: op = spu_decode_pkg::clgti;
			default: ;
		endcase
		case (word[0:8])	// ri16
			9'b010000011: op = spu_decode_pkg::ilh;
			9'b010000010: op = spu_decode_pkg::ilhu;
			9'b011000001: op = spu_decode_pkg::iohl;
			default: ;
		endcase
		case (word[0:9])	// ri8
			10'b0111011000: op = spu_decode_pkg::cflts;
			10'b0111011001: op = spu_decode_pkg::cfltu;
			default: ;
		endcase
		if (word[0:6] == 7'b0100001)
			op = spu_decode_pkg::ila;
		case (word[0:3])	// rrr
			4'b1100: op = spu_decode_pkg::mpya;
			4'b1110: op = spu_decode_pkg::fma;
			4'b1111: op = spu_decode_pkg::fms;
			default: ;
		endcase
	end

	always_comb begin
		if (op inside {[spu_decode_pkg::mpya : spu_decode_pkg::fms]})
			fmt = spu_decode_pkg::fmt_rrr;
		else if (op == spu_decode_pkg::ila)
			fmt = spu_decode_pkg::fmt_ri18;
		else if (op inside {[spu_decode_pkg::cflts : spu_decode_pkg::cfltu]})
			fmt = spu_decode_pkg::fmt_ri8;
		else if (op inside {[spu_decode_pkg::ilh : spu_decode_pkg::iohl]})
			fmt = spu_decode_pkg::fmt_ri16;
		else if (op inside {[spu_decode_pkg::mpyi : spu_decode_pkg::mpyui],
				[spu_decode_pkg::ahi : spu_decode_pkg::clgti]})
			fmt = spu_decode_pkg::fmt_ri10;
		else if (op inside {[spu_decode_pkg::shli : spu_decode_pkg::rotmai]})
			fmt = spu_decode_pkg::fmt_ri7;
		else
			fmt = spu_decode_pkg::fmt_rr;

		if (op inside {[spu_decode_pkg::shlh : spu_decode_pkg::rotmai]})
			unit = spu_decode_pkg::unit_fx2;
		else if (op inside {[spu_decode_pkg::cntb : spu_decode_pkg::sumb]})
			unit = spu_decode_pkg::unit_byte;
		else if (op inside {[spu_decode_pkg::ila : spu_decode_pkg::clgt]})
			unit = spu_decode_pkg::unit_fx1;
		else
			unit = spu_decode_pkg::unit_fp;	// nop lands here too

		case (fmt)
			spu_decode_pkg::fmt_ri7: imm = {{11{word[11]}}, word[11:17]};
			spu_decode_pkg::fmt_ri8: imm = {{10{word[10]}}, word[10:17]};
			spu_decode_pkg::fmt_ri10: imm = {{8{word[8]}}, word[8:17]};
			spu_decode_pkg::fmt_ri16: imm = {{2{word[9]}}, word[9:24]};
			spu_decode_pkg::fmt_ri18: imm = word[7:24];
			default: imm = '0;
		endcase
	end

	always_comb begin
		slot.instr = word;
		slot.op = op;
		slot.format = fmt;
		slot.unit = unit;
		slot.rt = (fmt == spu_decode_pkg::fmt_rrr) ? word[4:10] : word[25:31];
		slot.ra = word[18:24];
		slot.rb = word[11:17];
		slot.rc = word[25:31];	// only meaningful for rrr
		slot.imm = imm;
		slot.reg_write = !(op inside {spu_decode_pkg::nop, spu_decode_pkg::even_none});
	end

endmodule

// File: source/odd_decoder.sv
`timescale 1ns/10ps

module odd_decoder (
	input spu_decode_pkg::instr_t word,
	output spu_decode_pkg::odd_slot_t slot
);

	spu_decode_pkg::odd_op_e op;
	spu_decode_pkg::format_e fmt;
	spu_decode_pkg::odd_unit_e unit;
	spu_decode_pkg::imm_t imm;

	always_comb begin
		case (word[0:10])	// rr and ri7
			11'b00111011011: op = spu_decode_pkg::shlqbi;
			11'b00111011111: op = spu_decode_pkg::shlqby;
			11'b00111011000: op = spu_decode_pkg::rotqbi;
			11'b00111011100: op = spu_decode_pkg::rotqby;
			11'b00110110010: op = spu_decode_pkg::gbb;
			11'b00110110001: op = spu_decode_pkg::gbh;
			11'b00110110000: op = spu_decode_pkg::gb;
			11'b00111000100: op = spu_decode_pkg::lqx;
			11'b00101000100: op = spu_decode_pkg::stqx;
			11'b00110101000: op = spu_decode_pkg::bi;
			11'b00000000001: op = spu_decode_pkg::lnop;
			11'b00111111011: op = spu_decode_pkg::shlqbii;
			11'b00111111111: op = spu_decode_pkg::shlqbyi;
			11'b00111111000: op = spu_decode_pkg::rotqbii;
			11'b00111111100: op = spu_decode_pkg::rotqbyi;
			default: op = spu_decode_pkg::odd_none;
		endcase
		case (word[0:8])	// ri16
			9'b001100001: op = spu_decode_pkg::lqa;
			9'b001000001: op = spu_decode_pkg::stqa;
			9'b001100100: op = spu_decode_pkg::br;
			9'b001100000: op = spu_decode_pkg::bra;
			9'b001100110: op = spu_decode_pkg::brsl;
			9'b001000010: op = spu_decode_pkg::brnz;
			9'b001000000: op = spu_decode_pkg::brz;
			default: ;
		endcase
		case (word[0:7])	// ri10
			8'b00110100: op = spu_decode_pkg::lqd;
			8'b00100100: op = spu_decode_pkg::stqd;
			default: ;
		endcase
	end

	always_comb begin
		if (op inside {[spu_decode_pkg::lqd : spu_decode_pkg::stqd]})
			fmt = spu_decode_pkg::fmt_ri10;
		else if (op inside {[spu_decode_pkg::lqa : spu_decode_pkg::stqa],
				[spu_decode_pkg::br : spu_decode_pkg::brz]})
			fmt = spu_decode_pkg::fmt_ri16;
		else if (op inside {[spu_decode_pkg::shlqbii : spu_decode_pkg::rotqbyi]})
			fmt = spu_decode_pkg::fmt_ri7;
		else
			fmt = spu_decode_pkg::fmt_rr;

		if (op inside {[spu_decode_pkg::lqd : spu_decode_pkg::stqx]})
			unit = spu_decode_pkg::unit_ls;
		else if (op inside {[spu_decode_pkg::br : spu_decode_pkg::bi]})
			unit = spu_decode_pkg::unit_br;
		else
			unit = spu_decode_pkg::unit_perm;

		case (fmt)
			spu_decode_pkg::fmt_ri7: imm = {{11{word[11]}}, word[11:17]};
			spu_decode_pkg::fmt_ri10: imm = {{8{word[8]}}, word[8:17]};
			spu_decode_pkg::fmt_ri16: imm = {{2{word[9]}}, word[9:24]};
			default: imm = '0;
		endcase
	end

	always_comb begin
		slot.instr = word;
		slot.op = op;
		slot.format = fmt;
		slot.unit = unit;
		slot.rt = word[25:31];
		slot.ra = word[18:24];
		slot.rb = word[11:17];
		slot.imm = imm;
		// stores, plain branches and lnop leave rt alone
		slot.reg_write = !(op inside {spu_decode_pkg::odd_none, spu_decode_pkg::lnop,
			spu_decode_pkg::stqd, spu_decode_pkg::stqa, spu_decode_pkg::stqx,
			spu_decode_pkg::br, spu_decode_pkg::bra, spu_decode_pkg::brnz,
			spu_decode_pkg::brz, spu_decode_pkg::bi});
	end

endmodule

// File: source/pair_steer.sv
`timescale 1ns/10ps

module pair_steer (
	input spu_decode_pkg::even_slot_t first_even,
	input spu_decode_pkg::even_slot_t second_even,
	input spu_decode_pkg::odd_slot_t first_odd_slot,
	input spu_decode_pkg::odd_slot_t second_odd_slot,
	input spu_decode_pkg::fetch_pair_t pair,
	output spu_decode_pkg::pair_kind_e kind,
	output spu_decode_pkg::issue_packet_t now_packet,
	output spu_decode_pkg::even_slot_t defer_even,
	output spu_decode_pkg::odd_slot_t defer_odd,
	output logic defer_is_odd
);

	logic first_is_odd;
	logic second_is_odd;
	logic same_rt;
	spu_decode_pkg::even_slot_t first_as_even;
	spu_decode_pkg::even_slot_t second_as_even;
	spu_decode_pkg::even_slot_t dual_even;
	spu_decode_pkg::odd_slot_t dual_odd;

	// an unrecognized word still goes down the even pipe, as a nop
	function automatic spu_decode_pkg::even_slot_t as_even(input spu_decode_pkg::even_slot_t s);
		as_even = s;
		if (s.op == spu_decode_pkg::even_none)
			as_even.op = spu_decode_pkg::nop;	// reg_write is already low
	endfunction

	assign first_is_odd = (first_even.op == spu_decode_pkg::even_none)
		&& (first_odd_slot.op != spu_decode_pkg::odd_none);
	assign second_is_odd = (second_even.op == spu_decode_pkg::even_none)
		&& (second_odd_slot.op != spu_decode_pkg::odd_none);
	assign first_as_even = as_even(first_even);
	assign second_as_even = as_even(second_even);

	// slot contents if the pair goes out together
	assign dual_even = first_is_odd ? second_as_even : first_as_even;
	assign dual_odd = first_is_odd ? first_odd_slot : second_odd_slot;
	assign same_rt = dual_even.reg_write && dual_odd.reg_write
		&& (dual_even.rt == dual_odd.rt);

	always_comb begin
		if (pair.first == '0)
			kind = spu_decode_pkg::pair_stop;
		else if (pair.second == '0)
			kind = spu_decode_pkg::pair_last;
		else if ((first_is_odd != second_is_odd) && !same_rt)
			kind = spu_decode_pkg::pair_dual;
		else
			kind = spu_decode_pkg::pair_split;	// pipe clash or waw on rt
	end

	always_comb begin
		now_packet = '0;
		if (kind == spu_decode_pkg::pair_dual) begin
			now_packet.even_slot = dual_even;
			now_packet.odd_slot = dual_odd;
			now_packet.first_odd = first_is_odd;
		end else if (kind != spu_decode_pkg::pair_stop) begin
			if (first_is_odd)
				now_packet.odd_slot = first_odd_slot;
			else
				now_packet.even_slot = first_as_even;
		end
	end

	// second word, used only when the pair splits
	always_comb begin
		defer_even = '0;
		defer_odd = '0;
		defer_is_odd = second_is_odd;
		if (second_is_odd)
			defer_odd = second_odd_slot;
		else
			defer_even = second_as_even;
	end

endmodule

// File: source/issue_sequencer.sv
`timescale 1ns/10ps

module issue_sequencer #(
	parameter int PC_WIDTH = 8
) (
	input logic clk,
	input logic reset,
	input logic [PC_WIDTH-1:0] pc,
	input logic pair_valid,
	input logic issue_hold,
	input spu_decode_pkg::pair_kind_e kind,
	input spu_decode_pkg::issue_packet_t now_packet,
	input spu_decode_pkg::even_slot_t defer_even,
	input spu_decode_pkg::odd_slot_t defer_odd,
	input logic defer_is_odd,
	output spu_decode_pkg::issue_packet_t packet,
	output logic issue_valid,
	output logic fetch_stall,
	output logic [PC_WIDTH-1:0] stall_pc,
	output logic finished
);

	typedef enum logic [1:0] {
		seq_idle,
		seq_deferred,	// second half of a split is waiting
		seq_finished
	} seq_state_e;

	seq_state_e state;
	logic accept;
	logic held_is_odd;
	spu_decode_pkg::even_slot_t held_even;
	spu_decode_pkg::odd_slot_t held_odd;
	spu_decode_pkg::issue_packet_t deferred_packet;

	assign fetch_stall = issue_hold || (state != seq_idle);
	assign accept = pair_valid && !fetch_stall;
	assign finished = (state == seq_finished);

	always_comb begin
		deferred_packet = '0;	// first_odd stays low
		if (held_is_odd)
			deferred_packet.odd_slot = held_odd;
		else
			deferred_packet.even_slot = held_even;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= seq_idle;
			issue_valid <= 1'b0;
			stall_pc <= '0;
		end else if (!issue_hold) begin
			case (state)
				seq_idle: begin
					issue_valid <= accept && (kind != spu_decode_pkg::pair_stop);
					if (accept && kind == spu_decode_pkg::pair_split) begin
						state <= seq_deferred;
						stall_pc <= pc;	// fetch re-presents this pair
					end else if (accept && kind != spu_decode_pkg::pair_dual) begin
						state <= seq_finished;	// stop word seen
					end
				end
				seq_deferred: begin
					issue_valid <= 1'b1;
					state <= seq_idle;
					stall_pc <= '0;
				end
				default: issue_valid <= 1'b0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			packet <= now_packet;
		else if (state == seq_deferred && !issue_hold)
			packet <= deferred_packet;
		if (accept && kind == spu_decode_pkg::pair_split) begin
			held_even <= defer_even;
			held_odd <= defer_odd;
			held_is_odd <= defer_is_odd;
		end
	end

endmodule

// File: source/spu_decode_stage.sv
`timescale 1ns/10ps

module spu_decode_stage #(
	parameter int PC_WIDTH = 8
) (
	input logic clk,
	input logic reset,
	input spu_decode_pkg::fetch_pair_t pair,
	input logic [PC_WIDTH-1:0] pc,
	input logic pair_valid,
	input logic issue_hold,
	output spu_decode_pkg::issue_packet_t packet,
	output logic issue_valid,
	output logic fetch_stall,
	output logic [PC_WIDTH-1:0] stall_pc,
	output logic finished
);

	spu_decode_pkg::even_slot_t first_even;
	spu_decode_pkg::even_slot_t second_even;
	spu_decode_pkg::odd_slot_t first_odd_slot;
	spu_decode_pkg::odd_slot_t second_odd_slot;
	spu_decode_pkg::pair_kind_e kind;
	spu_decode_pkg::issue_packet_t now_packet;
	spu_decode_pkg::even_slot_t defer_even;
	spu_decode_pkg::odd_slot_t defer_odd;
	logic defer_is_odd;

	// each word is decoded both ways, steering picks one
	even_decoder u_first_even (.word(pair.first), .slot(first_even));
	even_decoder u_second_even (.word(pair.second), .slot(second_even));
	odd_decoder u_first_odd (.word(pair.first), .slot(first_odd_slot));
	odd_decoder u_second_odd (.word(pair.second), .slot(second_odd_slot));

	pair_steer u_steer (
		.first_even(first_even),
		.second_even(second_even),
		.first_odd_slot(first_odd_slot),
		.second_odd_slot(second_odd_slot),
		.pair(pair),
		.kind(kind),
		.now_packet(now_packet),
		.defer_even(defer_even),
		.defer_odd(defer_odd),
		.defer_is_odd(defer_is_odd)
	);

	issue_sequencer #(.PC_WIDTH(PC_WIDTH)) u_seq (
		.clk(clk),
		.reset(reset),
		.pc(pc),
		.pair_valid(pair_valid),
		.issue_hold(issue_hold),
		.kind(kind),
		.now_packet(now_packet),
		.defer_even(defer_even),
		.defer_odd(defer_odd),
		.defer_is_odd(defer_is_odd),
		.packet(packet),
		.issue_valid(issue_valid),
		.fetch_stall(fetch_stall),
		.stall_pc(stall_pc),
		.finished(finished)
	);

endmodule

// File: dv/spu_decode_cases.svh
`ifndef SPU_DECODE_CASES_SVH
`define SPU_DECODE_CASES_SVH

typedef struct packed {
	spu_decode_pkg::instr_t word;
	logic is_odd;	// odd-class word
	spu_decode_pkg::even_op_e eop;
	spu_decode_pkg::odd_op_e oop;
	logic [1:0] unit;
	spu_decode_pkg::format_e fmt;
	spu_decode_pkg::reg_addr_t rt;
	spu_decode_pkg::imm_t imm;
	logic wr;
} word_exp_t;

typedef struct packed {
	word_exp_t a;	// first in program order
	word_exp_t b;
	logic [7:0] pc;
} case_row_t;

localparam int N_CASES = 18;

function automatic word_exp_t ev(input spu_decode_pkg::instr_t w,
		input spu_decode_pkg::even_op_e op, input spu_decode_pkg::even_unit_e u,
		input spu_decode_pkg::format_e f, input logic [6:0] rt, input logic [17:0] imm,
		input logic wr);
	ev = '{w, 1'b0, op, spu_decode_pkg::odd_none, u, f, rt, imm, wr};
endfunction

function automatic word_exp_t od(input spu_decode_pkg::instr_t w,
		input spu_decode_pkg::odd_op_e op, input spu_decode_pkg::odd_unit_e u,
		input spu_decode_pkg::format_e f, input logic [6:0] rt, input logic [17:0] imm,
		input logic wr);
	od = '{w, 1'b1, spu_decode_pkg::even_none, op, u, f, rt, imm, wr};
endfunction

function automatic case_row_t mk_row(input word_exp_t a, input word_exp_t b, input int pc);
	mk_row = '{a, b, pc[7:0]};
endfunction

// field layout, opcode at bit 0: rrr op4 rt rb ra rc, rr op11 rb ra rt
task automatic load_cases(output case_row_t rows [N_CASES]);
	word_exp_t w_nop, w_lnop, w_a, w_cntb, w_ai, w_lqd, w_lqx;
	w_nop = ev({11'b01000000001, 21'd0}, spu_decode_pkg::nop, spu_decode_pkg::unit_fp,
		spu_decode_pkg::fmt_rr, 7'd0, 18'd0, 1'b0);
	w_lnop = od({11'b00000000001, 21'd0}, spu_decode_pkg::lnop, spu_decode_pkg::unit_perm,
		spu_decode_pkg::fmt_rr, 7'd0, 18'd0, 1'b0);
	w_a = ev({11'b00011000000, 7'd1, 7'd2, 7'd15}, spu_decode_pkg::a_op,
		spu_decode_pkg::unit_fx1, spu_decode_pkg::fmt_rr, 7'd15, 18'd0, 1'b1);
	w_cntb = ev({11'b01010110100, 7'd0, 7'd4, 7'd17}, spu_decode_pkg::cntb,
		spu_decode_pkg::unit_byte, spu_decode_pkg::fmt_rr, 7'd17, 18'd0, 1'b1);
	w_ai = ev({8'b00011100, 10'h3fd, 7'd6, 7'd14}, spu_decode_pkg::ai,
		spu_decode_pkg::unit_fx1, spu_decode_pkg::fmt_ri10, 7'd14, 18'h3fffd, 1'b1);
	w_lqd = od({8'b00110100, 10'h010, 7'd7, 7'd20}, spu_decode_pkg::lqd,
		spu_decode_pkg::unit_ls, spu_decode_pkg::fmt_ri10, 7'd20, 18'h10, 1'b1);
	w_lqx = od({11'b00111000100, 7'd9, 7'd8, 7'd24}, spu_decode_pkg::lqx,
		spu_decode_pkg::unit_ls, spu_decode_pkg::fmt_rr, 7'd24, 18'd0, 1'b1);

	rows[0] = mk_row(ev({4'b1100, 7'd10, 7'd2, 7'd3, 7'd4}, spu_decode_pkg::mpya,
		spu_decode_pkg::unit_fp, spu_decode_pkg::fmt_rrr, 7'd10, 18'd0, 1'b1), w_lnop, 16);
	rows[1] = mk_row(ev({7'b0100001, 18'h20005, 7'd11}, spu_decode_pkg::ila,
		spu_decode_pkg::unit_fx1, spu_decode_pkg::fmt_ri18, 7'd11, 18'h20005, 1'b1), w_lnop, 20);
	rows[2] = mk_row(ev({10'b0111011000, 8'h85, 7'd5, 7'd12}, spu_decode_pkg::cflts,
		spu_decode_pkg::unit_fp, spu_decode_pkg::fmt_ri8, 7'd12, 18'h3ff85, 1'b1), w_lnop, 24);
	rows[3] = mk_row(ev({9'b010000011, 16'h8001, 7'd13}, spu_decode_pkg::ilh,
		spu_decode_pkg::unit_fx1, spu_decode_pkg::fmt_ri16, 7'd13, 18'h38001, 1'b1), w_lnop, 28);
	rows[4] = mk_row(w_ai, w_lnop, 32);
	rows[5] = mk_row(w_a, w_lnop, 36);
	rows[6] = mk_row(ev({11'b00001111011, 7'h7c, 7'd3, 7'd16}, spu_decode_pkg::shli,
		spu_decode_pkg::unit_fx2, spu_decode_pkg::fmt_ri7, 7'd16, 18'h3fffc, 1'b1), w_lnop, 40);
	rows[7] = mk_row(w_cntb, w_lnop, 44);
	rows[8] = mk_row(w_nop, w_lqd, 48);
	rows[9] = mk_row(w_nop, od({8'b00100100, 10'h200, 7'd7, 7'd21}, spu_decode_pkg::stqd,
		spu_decode_pkg::unit_ls, spu_decode_pkg::fmt_ri10, 7'd21, 18'h3fe00, 1'b0), 52);
	rows[10] = mk_row(w_nop, od({9'b001100110, 16'h0040, 7'd22}, spu_decode_pkg::brsl,
		spu_decode_pkg::unit_br, spu_decode_pkg::fmt_ri16, 7'd22, 18'h40, 1'b1), 56);
	rows[11] = mk_row(w_nop, od({9'b001100100, 16'hfff0, 7'd0}, spu_decode_pkg::br,
		spu_decode_pkg::unit_br, spu_decode_pkg::fmt_ri16, 7'd0, 18'h3fff0, 1'b0), 60);
	rows[12] = mk_row(w_nop, od({11'b00111111100, 7'h03, 7'd8, 7'd23}, spu_decode_pkg::rotqbyi,
		spu_decode_pkg::unit_perm, spu_decode_pkg::fmt_ri7, 7'd23, 18'h3, 1'b1), 64);
	rows[13] = mk_row(w_nop, w_lqx, 68);
	rows[14] = mk_row(od({9'b001100001, 16'h0100, 7'd25}, spu_decode_pkg::lqa,
		spu_decode_pkg::unit_ls, spu_decode_pkg::fmt_ri16, 7'd25, 18'h100, 1'b1),
		ev({11'b01011000100, 7'd1, 7'd2, 7'd26}, spu_decode_pkg::fa,
		spu_decode_pkg::unit_fp, spu_decode_pkg::fmt_rr, 7'd26, 18'd0, 1'b1), 72);
	rows[15] = mk_row(w_a, w_cntb, 76);	// both even
	rows[16] = mk_row(w_lqd, w_lqx, 80);	// both odd
	rows[17] = mk_row(ev({8'b00011100, 10'h001, 7'd1, 7'd30}, spu_decode_pkg::ai,
		spu_decode_pkg::unit_fx1, spu_decode_pkg::fmt_ri10, 7'd30, 18'h1, 1'b1),
		od({8'b00110100, 10'h004, 7'd2, 7'd30}, spu_decode_pkg::lqd,
		spu_decode_pkg::unit_ls, spu_decode_pkg::fmt_ri10, 7'd30, 18'h4, 1'b1), 84);
endtask

`endif

// File: dv/spu_decode_tb.sv
`timescale 1ns/10ps

module spu_decode_tb;

	`include "spu_decode_cases.svh"

	localparam int PC_W = 8;
	localparam int WATCHDOG_NS = ((2 * N_CASES + 12) * 6 + 2 * 8) * 100;

	logic clk;
	logic reset;
	spu_decode_pkg::fetch_pair_t pair;
	logic [PC_W-1:0] pc;
	logic pair_valid;
	logic issue_hold;
	spu_decode_pkg::issue_packet_t packet;
	logic issue_valid;
	logic fetch_stall;
	logic [PC_W-1:0] stall_pc;
	logic finished;

	case_row_t rows [N_CASES];
	case_row_t cur_row;
	word_exp_t zero_w;
	spu_decode_pkg::issue_packet_t exp_q [$];
	logic drv_valid;
	logic hold_mode;
	logic pending;	// split second half not yet issued
	logic fin;
	logic exp_valid;
	logic [PC_W-1:0] held_pc;
	int mismatches;
	int failures;

	spu_decode_stage #(.PC_WIDTH(PC_W)) dut (
		.clk(clk), .reset(reset), .pair(pair), .pc(pc), .pair_valid(pair_valid),
		.issue_hold(issue_hold), .packet(packet), .issue_valid(issue_valid),
		.fetch_stall(fetch_stall), .stall_pc(stall_pc), .finished(finished)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the decode stage stopped making progress");
		$display("STATUS: FAIL");
		$finish;
	end

	task automatic check_even(input string name, input spu_decode_pkg::even_slot_t got,
			input spu_decode_pkg::even_slot_t exp);
		if (got !== exp) begin
			$display("MISMATCH %0t %s got %h exp %h", $time, name, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_odd(input string name, input spu_decode_pkg::odd_slot_t got,
			input spu_decode_pkg::odd_slot_t exp);
		if (got !== exp) begin
			$display("MISMATCH %0t %s got %h exp %h", $time, name, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH %0t %s got %b exp %b", $time, name, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_pc(input string name, input logic [PC_W-1:0] got,
			input logic [PC_W-1:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %0t %s got %h exp %h", $time, name, got, exp);
			mismatches++;
		end
	endtask

	// slot contents follow the isa field positions
	function automatic spu_decode_pkg::even_slot_t exp_even(input word_exp_t w);
		exp_even.instr = w.word;
		exp_even.op = w.eop;
		exp_even.format = w.fmt;
		exp_even.unit = spu_decode_pkg::even_unit_e'(w.unit);
		exp_even.rt = w.rt;
		exp_even.ra = w.word[18:24];
		exp_even.rb = w.word[11:17];
		exp_even.rc = w.word[25:31];
		exp_even.imm = w.imm;
		exp_even.reg_write = w.wr;
	endfunction

	function automatic spu_decode_pkg::odd_slot_t exp_odd(input word_exp_t w);
		exp_odd.instr = w.word;
		exp_odd.op = w.oop;
		exp_odd.format = w.fmt;
		exp_odd.unit = spu_decode_pkg::odd_unit_e'(w.unit);
		exp_odd.rt = w.rt;
		exp_odd.ra = w.word[18:24];
		exp_odd.rb = w.word[11:17];
		exp_odd.imm = w.imm;
		exp_odd.reg_write = w.wr;
	endfunction

	function automatic spu_decode_pkg::issue_packet_t alone(input word_exp_t w);
		alone = '0;
		if (w.is_odd)
			alone.odd_slot = exp_odd(w);
		else
			alone.even_slot = exp_even(w);
	endfunction

	function automatic spu_decode_pkg::pair_kind_e expect_kind(input case_row_t r);
		if (r.a.word == '0)
			expect_kind = spu_decode_pkg::pair_stop;
		else if (r.b.word == '0)
			expect_kind = spu_decode_pkg::pair_last;
		else if (r.a.is_odd != r.b.is_odd && !(r.a.wr && r.b.wr && r.a.rt == r.b.rt))
			expect_kind = spu_decode_pkg::pair_dual;
		else
			expect_kind = spu_decode_pkg::pair_split;
	endfunction

	// push the packets an accepted pair must produce, in issue order
	task automatic queue_expected(input case_row_t r, input spu_decode_pkg::pair_kind_e k);
		spu_decode_pkg::issue_packet_t p;
		p = '0;
		if (k == spu_decode_pkg::pair_dual) begin
			p.even_slot = exp_even(r.a.is_odd ? r.b : r.a);
			p.odd_slot = exp_odd(r.a.is_odd ? r.a : r.b);
			p.first_odd = r.a.is_odd;
			exp_q.push_back(p);
		end else if (k != spu_decode_pkg::pair_stop) begin
			exp_q.push_back(alone(r.a));
			if (k == spu_decode_pkg::pair_split)
				exp_q.push_back(alone(r.b));
		end
	endtask

	// drive at the falling edge, check, then predict the next rising edge
	task automatic step(output logic accepted);
		spu_decode_pkg::issue_packet_t p;
		spu_decode_pkg::pair_kind_e k;
		logic hold;
		logic exp_stall;
		@(negedge clk);
		hold = hold_mode && ($urandom % 4 == 0);
		issue_hold = hold;
		pair = {cur_row.a.word, cur_row.b.word};
		pc = cur_row.pc;
		pair_valid = drv_valid;
		#1;
		exp_stall = hold || pending || fin;
		check_bit("fetch_stall", fetch_stall, exp_stall);
		check_bit("finished", finished, fin);
		check_bit("issue_valid", issue_valid, exp_valid);
		check_pc("stall_pc", stall_pc, pending ? held_pc : '0);
		if (issue_valid && !hold) begin
			if (exp_q.size() == 0) begin
				$display("unexpected packet issued at %0t", $time);
				failures++;
			end else begin
				p = exp_q.pop_front();
				check_even("packet.even_slot", packet.even_slot, p.even_slot);
				check_odd("packet.odd_slot", packet.odd_slot, p.odd_slot);
				check_bit("packet.first_odd", packet.first_odd, p.first_odd);
			end
		end
		accepted = drv_valid && !exp_stall;
		if (!hold) begin
			k = expect_kind(cur_row);
			exp_valid = pending || (accepted && k != spu_decode_pkg::pair_stop);
			pending = 1'b0;
			if (accepted) begin
				queue_expected(cur_row, k);
				if (k == spu_decode_pkg::pair_split) begin
					pending = 1'b1;
					held_pc = cur_row.pc;
				end else if (k != spu_decode_pkg::pair_dual) begin
					fin = 1'b1;
				end
			end
		end
	endtask

	task automatic apply_row(input case_row_t r);
		logic acc;
		cur_row = r;
		drv_valid = 1'b1;
		acc = 1'b0;
		while (!acc)
			step(acc);
	endtask

	task automatic drain(input int idle_steps);
		logic acc;
		int n;
		drv_valid = 1'b0;
		n = 0;
		while ((exp_q.size() != 0 || pending) && n < 40) begin
			step(acc);
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("%0d expected packets never issued", exp_q.size());
			failures++;
			exp_q.delete();
		end
		drv_valid = fin;	// a finished stage must ignore further pairs
		repeat (idle_steps) begin
			step(acc);
			if (pair_valid && !fetch_stall) begin
				$display("finished stage was ready to accept a pair at %0t", $time);
				failures++;
			end
		end
		drv_valid = 1'b0;
	endtask

	task automatic do_reset();
		@(negedge clk);
		reset = 1'b1;
		issue_hold = 1'b0;
		pair_valid = 1'b0;
		repeat (8) @(negedge clk);
		reset = 1'b0;
		pending = 1'b0;
		fin = 1'b0;
		exp_valid = 1'b0;
		held_pc = '0;
		exp_q.delete();
	endtask

	initial begin
		void'($urandom(32'had67));
		reset = 1'b1;
		pair = '0;
		pc = '0;
		pair_valid = 1'b0;
		issue_hold = 1'b0;
		drv_valid = 1'b0;
		hold_mode = 1'b0;
		mismatches = 0;
		failures = 0;
		zero_w = '0;
		cur_row = '0;
		load_cases(rows);
		do_reset();
		for (int pass = 0; pass < 2; pass++) begin
			hold_mode = (pass == 1);	// second pass adds back-pressure
			for (int i = 0; i < N_CASES; i++)
				apply_row(rows[i]);
			drain(0);
		end
		hold_mode = 1'b0;
		apply_row(mk_row(rows[4].a, zero_w, 240));
		drain(4);
		do_reset();
		apply_row(mk_row(zero_w, rows[4].a, 244));
		drain(4);
		$display("errors: mismatches=%0d other=%0d", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: spu_decode.f
+incdir+dv
source/spu_decode_pkg.sv
source/even_decoder.sv
source/odd_decoder.sv
source/pair_steer.sv
source/issue_sequencer.sv
source/spu_decode_stage.sv
dv/spu_decode_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= spu_decode_tb
FILELIST ?= spu_decode.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing

SRCS := $(wildcard source/*.sv) $(wildcard dv/*.sv) $(wildcard dv/*.svh)
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
